// File: verilog/z80Ed_params.svh
// Width macros shared by the ED-page core; include wherever a phase or data byte is sized.
`ifndef Z80ED_PARAMS_SVH
`define Z80ED_PARAMS_SVH

// ---------------------------------------------------------------------------
// phase counter
// ---------------------------------------------------------------------------

// the longest ED instruction here needs two execute phases.
`define ED_PHASE_W 2

// ---------------------------------------------------------------------------
// data path
// ---------------------------------------------------------------------------

`define ED_BYTE_W 8

`endif

// File: verilog/edPkg.sv
// Types for the ED-page core: opcode views, decoder control word and register state.
package edPkg;

`include "z80Ed_params.svh"

    // the same opcode byte seen as x/y/z and as x/p/q/z.
    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
    } edOpXyz_t;

    typedef struct packed {
        logic [1:0] x;
        logic [1:0] p;
        logic       q;
        logic [2:0] z;
    } edOpXpqz_t;

    typedef union packed {
        edOpXyz_t  xyz;
        edOpXpqz_t xpqz;
    } edOpcode_u;

    typedef enum logic [2:0] {aluPass, aluAdd, aluAdc, aluSub, aluSbc} edAluOp_e;

    typedef enum logic [2:0] {opaZero, opaA, opaL, opaH, opaI, opaR} edOpndA_e;

    typedef enum logic [1:0] {opbA, opbPairLow, opbPairHigh} edOpndB_e;

    typedef enum logic [1:0] {flagKeep, flagArith, flagWordLow, flagLoadIr} edFlagMode_e;

    // ---------------------------------------------------------------------------
    // decoder output, one word per execute phase
    // ---------------------------------------------------------------------------
    typedef struct packed {
        edAluOp_e    aluOp;
        edOpndA_e    opndA;
        edOpndB_e    opndB;
        edFlagMode_e flagMode;
        logic [1:0]  pair;
        logic        wrA;
        logic        wrI;
        logic        wrR;
        logic        wrL;
        logic        wrH;
        logic        setIm;
        logic [1:0]  imMode;
        logic        lastPhase;
    } edCtrl_t;

    typedef struct packed {
        logic [`ED_BYTE_W-1:0]   a;
        logic [`ED_BYTE_W-1:0]   f;
        logic [2*`ED_BYTE_W-1:0] bc;
        logic [2*`ED_BYTE_W-1:0] de;
        logic [2*`ED_BYTE_W-1:0] hl;
        logic [2*`ED_BYTE_W-1:0] sp;
        logic [`ED_BYTE_W-1:0]   i;
        logic [`ED_BYTE_W-1:0]   r;
        logic [1:0]              im;
        logic                    iff2;
    } edState_t;

endpackage

// File: verilog/edOpDecoder.sv
// Combinational ED-page decoder; maps the held opcode and phase to the core control word.
`timescale 1ns/1ps
`include "z80Ed_params.svh"

module edOpDecoder
    import edPkg::*;
(
    input  edOpcode_u              heldOp,
    input  logic [`ED_PHASE_W-1:0] phase,
    input  logic                   busy,
    output edCtrl_t                ctrl
);

    always_comb begin
        ctrl = '0;
        if (busy) begin
            // anything not matched below runs as a single-phase no-op.
            ctrl.lastPhase = 1'b1;
            if (heldOp.xyz.x == 2'd1) begin
                case (heldOp.xyz.z)
                    // NEG computes 0 - A.
                    3'd4: begin
                        ctrl.aluOp    = aluSub;
                        ctrl.opndA    = opaZero;
                        ctrl.opndB    = opbA;
                        ctrl.flagMode = flagArith;
                        ctrl.wrA      = 1'b1;
                    end
                    // IM n; y mirrors every four codes.
                    3'd6: begin
                        ctrl.setIm = 1'b1;
                        case (heldOp.xyz.y[1:0])
                            2'd2:    ctrl.imMode = 2'd1;
                            2'd3:    ctrl.imMode = 2'd2;
                            default: ctrl.imMode = 2'd0;
                        endcase
                    end
                    3'd7: begin
                        case (heldOp.xyz.y)
                            3'd0: begin
                                ctrl.opndA = opaA;
                                ctrl.wrI   = 1'b1;
                            end
                            3'd1: begin
                                ctrl.opndA = opaA;
                                ctrl.wrR   = 1'b1;
                            end
                            3'd2: begin
                                ctrl.opndA    = opaI;
                                ctrl.flagMode = flagLoadIr;
                                ctrl.wrA      = 1'b1;
                            end
                            3'd3: begin
                                ctrl.opndA    = opaR;
                                ctrl.flagMode = flagLoadIr;
                                ctrl.wrA      = 1'b1;
                            end
                            default: begin
                                ctrl.lastPhase = 1'b1;
                            end
                        endcase
                    end
                    // ---------------------------------------------------------------------------
                    // ADC/SBC HL,rr in two byte passes, low byte first
                    // ---------------------------------------------------------------------------
                    3'd2: begin
                        ctrl.aluOp = heldOp.xpqz.q ? aluAdc : aluSbc;
                        ctrl.pair  = heldOp.xpqz.p;
                        case (phase)
                            2'd0: begin
                                ctrl.opndA     = opaL;
                                ctrl.opndB     = opbPairLow;
                                ctrl.flagMode  = flagWordLow;
                                ctrl.wrL       = 1'b1;
                                ctrl.lastPhase = 1'b0;
                            end
                            2'd1: begin
                                ctrl.opndA    = opaH;
                                ctrl.opndB    = opbPairHigh;
                                ctrl.flagMode = flagArith;
                                ctrl.wrH      = 1'b1;
                            end
                            default: begin
                                // a stray phase only finishes the instruction.
                                ctrl.aluOp = aluPass;
                            end
                        endcase
                    end
                    default: begin
                        ctrl.lastPhase = 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/edSequencer.sv
// Instruction sequencer; owns the opcode valid/ready handshake and steps execute phases.
`timescale 1ns/1ps

module edSequencer
    import edPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      opValid,
    output logic      opReady,
    input  edOpcode_u opCode,
    input  logic      lastPhase,
    output edOpcode_u heldOp,
    output logic      busy,
    output logic      phaseClear,
    output logic      phaseStep
);

    typedef enum logic {seqIdle, seqExec} seqState_e;

    seqState_e seqState;
    logic      opTake;

    assign opReady    = (seqState == seqIdle);
    assign busy       = (seqState == seqExec);
    assign opTake     = opValid && opReady;
    assign phaseClear = opTake;
    assign phaseStep  = busy;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            seqState <= seqIdle;
        end else begin
            case (seqState)
                seqIdle: begin
                    if (opTake) begin
                        seqState <= seqExec;
                    end
                end
                seqExec: begin
                    // the decoder flags the final phase of the current opcode.
                    if (lastPhase) begin
                        seqState <= seqIdle;
                    end
                end
                default: seqState <= seqIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (opTake) begin
            heldOp <= opCode;
        end
    end

endmodule

// File: verilog/phaseTimer.sv
// Extended-opcode phase counter; cleared on opcode accept, stepped once per execute cycle.
`timescale 1ns/1ps
`include "z80Ed_params.svh"

module phaseTimer (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   phaseClear,
    input  logic                   phaseStep,
    output logic [`ED_PHASE_W-1:0] phase
);

    // the counter sticks at its top value instead of wrapping to phase zero.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase <= '0;
        end else if (phaseClear) begin
            phase <= '0;
        end else if (phaseStep && (phase != '1)) begin
            phase <= phase + 1'b1;
        end
    end

endmodule

// File: verilog/edAlu.sv
// 8-bit ALU for the ED page; add, subtract and pass with Z80 flags in F layout.
`timescale 1ns/1ps
`include "z80Ed_params.svh"

module edAlu
    import edPkg::*;
(
    input  edAluOp_e              op,
    input  logic [`ED_BYTE_W-1:0] opndA,
    input  logic [`ED_BYTE_W-1:0] opndB,
    input  logic                  carryIn,
    output logic [`ED_BYTE_W-1:0] result,
    output logic [`ED_BYTE_W-1:0] flags
);

    logic [`ED_BYTE_W:0] wide;
    logic [4:0]          nibble;
    logic                useCarry;
    logic                subtract;
    logic                passOnly;
    logic                overflow;

    always_comb begin
        useCarry = ((op == aluAdc) || (op == aluSbc)) ? carryIn : 1'b0;
        subtract = (op == aluSub) || (op == aluSbc);
        passOnly = !((op == aluAdd) || (op == aluAdc) || subtract);
        if (subtract) begin
            wide     = {1'b0, opndA} - {1'b0, opndB} - {8'd0, useCarry};
            nibble   = {1'b0, opndA[3:0]} - {1'b0, opndB[3:0]} - {4'd0, useCarry};
            overflow = (opndA[7] != opndB[7]) && (wide[7] != opndA[7]);
        end else begin
            wide     = {1'b0, opndA} + {1'b0, opndB} + {8'd0, useCarry};
            nibble   = {1'b0, opndA[3:0]} + {1'b0, opndB[3:0]} + {4'd0, useCarry};
            overflow = (opndA[7] == opndB[7]) && (wide[7] != opndA[7]);
        end
        result = passOnly ? opndA : wide[`ED_BYTE_W-1:0];

        // ---------------------------------------------------------------------------
        // F layout: S Z Y H X PV N C
        // ---------------------------------------------------------------------------
        flags[7] = result[7];
        flags[6] = (result == '0);
        flags[5] = result[5];
        flags[4] = ~passOnly & nibble[4];
        flags[3] = result[3];
        flags[2] = ~passOnly & overflow;
        flags[1] = subtract;
        // bit 8 is the carry out, or the borrow when subtracting.
        flags[0] = ~passOnly & wide[`ED_BYTE_W];
    end

endmodule

// File: verilog/edRegFile.sv
// Architectural register file; operand muxing, write-back, F merge and the low-byte zero latch.
`timescale 1ns/1ps
`include "z80Ed_params.svh"

module edRegFile
    import edPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  loadEn,
    input  edState_t              loadState,
    input  logic                  busy,
    input  edCtrl_t               ctrl,
    input  logic [`ED_BYTE_W-1:0] result,
    input  logic [`ED_BYTE_W-1:0] aluFlags,
    output logic [`ED_BYTE_W-1:0] opndA,
    output logic [`ED_BYTE_W-1:0] opndB,
    output logic                  carry,
    output edState_t              state
);

    edState_t                regs;
    logic [2*`ED_BYTE_W-1:0] pairWord;
    logic [`ED_BYTE_W-1:0]   fNext;
    logic                    lowZero;

    assign state = regs;
    assign carry = regs.f[0];

    // ---------------------------------------------------------------------------
    // operand selection
    // ---------------------------------------------------------------------------
    always_comb begin
        case (ctrl.pair)
            2'd0:    pairWord = regs.bc;
            2'd1:    pairWord = regs.de;
            2'd2:    pairWord = regs.hl;
            default: pairWord = regs.sp;
        endcase
        case (ctrl.opndA)
            opaA:    opndA = regs.a;
            opaL:    opndA = regs.hl[7:0];
            opaH:    opndA = regs.hl[15:8];
            opaI:    opndA = regs.i;
            opaR:    opndA = regs.r;
            default: opndA = '0;
        endcase
        case (ctrl.opndB)
            opbA:        opndB = regs.a;
            opbPairLow:  opndB = pairWord[7:0];
            opbPairHigh: opndB = pairWord[15:8];
            default:     opndB = '0;
        endcase
    end

    always_comb begin
        case (ctrl.flagMode)
            flagArith: begin
                fNext = aluFlags;
                // the high pass of a word op only reports zero if the low byte was zero.
                if (ctrl.opndB == opbPairHigh) begin
                    fNext[6] = aluFlags[6] & lowZero;
                end
            end
            flagWordLow: fNext = {regs.f[7:1], aluFlags[0]};
            flagLoadIr:  fNext = {aluFlags[7:5], 1'b0, aluFlags[3], regs.iff2, 1'b0, regs.f[0]};
            default:     fNext = regs.f;
        endcase
    end

    // ---------------------------------------------------------------------------
    // write-back
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs.a    <= 8'hFF;
            regs.f    <= 8'hFF;
            regs.bc   <= 16'hFFFF;
            regs.de   <= 16'hFFFF;
            regs.hl   <= 16'hFFFF;
            regs.sp   <= 16'hFFFF;
            regs.i    <= '0;
            regs.r    <= '0;
            regs.im   <= '0;
            regs.iff2 <= 1'b0;
        end else if (loadEn && !busy) begin
            regs <= loadState;
        end else begin
            if (ctrl.wrA) begin
                regs.a <= result;
            end
            if (ctrl.wrI) begin
                regs.i <= result;
            end
            if (ctrl.wrR) begin
                regs.r <= result;
            end
            if (ctrl.wrL) begin
                regs.hl[7:0] <= result;
            end
            if (ctrl.wrH) begin
                regs.hl[15:8] <= result;
            end
            if (ctrl.setIm) begin
                regs.im <= ctrl.imMode;
            end
            regs.f <= fNext;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lowZero <= 1'b0;
        end else if (busy && (ctrl.flagMode == flagWordLow)) begin
            lowZero <= (result == '0);
        end
    end

endmodule

// File: verilog/edCoreTop.sv
// Top level of the ED-page execution core; wires sequencer, timer, decoder, ALU and registers.
`timescale 1ns/1ps
`include "z80Ed_params.svh"

module edCoreTop
    import edPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      opValid,
    output logic      opReady,
    input  edOpcode_u opCode,
    input  logic      loadEn,
    input  edState_t  loadState,
    output edState_t  coreState
);

    edOpcode_u              heldOp;
    logic                   busy;
    logic                   phaseClear;
    logic                   phaseStep;
    logic [`ED_PHASE_W-1:0] phase;
    edCtrl_t                ctrl;
    logic [`ED_BYTE_W-1:0]  opndA;
    logic [`ED_BYTE_W-1:0]  opndB;
    logic                   carry;
    logic [`ED_BYTE_W-1:0]  result;
    logic [`ED_BYTE_W-1:0]  aluFlags;

    edSequencer edSequencer_inst (
        .clk        (clk),
        .arstN      (arstN),
        .opValid    (opValid),
        .opReady    (opReady),
        .opCode     (opCode),
        .lastPhase  (ctrl.lastPhase),
        .heldOp     (heldOp),
        .busy       (busy),
        .phaseClear (phaseClear),
        .phaseStep  (phaseStep)
    );

    phaseTimer phaseTimer_inst (
        .clk        (clk),
        .arstN      (arstN),
        .phaseClear (phaseClear),
        .phaseStep  (phaseStep),
        .phase      (phase)
    );

    edOpDecoder edOpDecoder_inst (
        .heldOp (heldOp),
        .phase  (phase),
        .busy   (busy),
        .ctrl   (ctrl)
    );

    edAlu edAlu_inst (
        .op      (ctrl.aluOp),
        .opndA   (opndA),
        .opndB   (opndB),
        .carryIn (carry),
        .result  (result),
        .flags   (aluFlags)
    );

    edRegFile edRegFile_inst (
        .clk       (clk),
        .arstN     (arstN),
        .loadEn    (loadEn),
        .loadState (loadState),
        .busy      (busy),
        .ctrl      (ctrl),
        .result    (result),
        .aluFlags  (aluFlags),
        .opndA     (opndA),
        .opndB     (opndB),
        .carry     (carry),
        .state     (coreState)
    );

endmodule

// File: sim/edCoreTb.sv
// Directed testbench for the ED-page core; each test loads a state, runs one opcode and checks it.
`timescale 1ns/1ps

module edCoreTb
    import edPkg::*;
();

    localparam int TIMEOUT = 20;

    logic      clk;
    logic      arstN;
    logic      opValid;
    logic      opReady;
    edOpcode_u opCode;
    logic      loadEn;
    edState_t  loadState;
    edState_t  coreState;

    integer seed;
    int     errorCount;
    int     timeoutCount;

    edCoreTop edCoreTop_inst (
        .clk       (clk),
        .arstN     (arstN),
        .opValid   (opValid),
        .opReady   (opReady),
        .opCode    (opCode),
        .loadEn    (loadEn),
        .loadState (loadState),
        .coreState (coreState)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic compareField(input string what, input string field,
                                input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0t ns: %s, %s is %h, expected %h", $time, what, field, got, exp);
        end
    endtask

    task automatic checkState(input string what, input edState_t got, input edState_t exp);
        compareField(what, "a", {8'h00, got.a}, {8'h00, exp.a});
        compareField(what, "f", {8'h00, got.f}, {8'h00, exp.f});
        compareField(what, "bc", got.bc, exp.bc);
        compareField(what, "de", got.de, exp.de);
        compareField(what, "hl", got.hl, exp.hl);
        compareField(what, "sp", got.sp, exp.sp);
        compareField(what, "i", {8'h00, got.i}, {8'h00, exp.i});
        compareField(what, "r", {8'h00, got.r}, {8'h00, exp.r});
        compareField(what, "im", {14'd0, got.im}, {14'd0, exp.im});
        compareField(what, "iff2", {15'd0, got.iff2}, {15'd0, exp.iff2});
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        if (got != exp) begin
            errorCount++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // drivers
    // ------------------------------------------------------------------------
    // all driving and sampling happens 1 ns after a rising edge.
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic makeRandomState(output edState_t st);
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        w0 = $random(seed);
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        st.a    = w0[7:0];
        st.f    = w0[15:8];
        st.i    = w0[23:16];
        st.r    = w0[31:24];
        st.bc   = w1[15:0];
        st.de   = w1[31:16];
        st.hl   = w2[15:0];
        st.sp   = w2[31:16];
        st.im   = w3[1:0];
        st.iff2 = w3[2];
    endtask

    task automatic loadRegs(input edState_t st);
        loadState = st;
        loadEn    = 1'b1;
        nextCycle();
        loadEn    = 1'b0;
    endtask

    task automatic sendOpcode(input logic [7:0] code, input bit holdValid);
        int waitCycles;
        waitCycles = 0;
        opCode     = code;
        opValid    = 1'b1;
        while (!opReady && waitCycles < TIMEOUT) begin
            nextCycle();
            waitCycles++;
        end
        if (!opReady) begin
            timeoutCount++;
            $display("Timeout: the core never became ready to take opcode %h", code);
        end
        nextCycle();
        if (!holdValid) begin
            opValid = 1'b0;
        end
    endtask

    task automatic waitReady(output int busyCycles);
        busyCycles = 0;
        while (!opReady && busyCycles < TIMEOUT) begin
            busyCycles++;
            nextCycle();
        end
        if (!opReady) begin
            timeoutCount++;
            $display("Timeout: the core stayed busy and never raised opReady again");
        end
    endtask

    task automatic runOp(input string what, input logic [7:0] code, input edState_t exp,
                         input int expCycles);
        int cycles;
        sendOpcode(code, 1'b0);
        waitReady(cycles);
        checkCount({what, " busy cycles"}, cycles, expCycles);
        checkState(what, coreState, exp);
    endtask

    // NEG per the Z80 rules: 0 - A with borrow, half borrow and overflow.
    function automatic edState_t negModel(input edState_t st);
        edState_t   exp;
        logic [7:0] res;
        exp   = st;
        res   = 8'h00 - st.a;
        exp.a = res;
        exp.f = {res[7], res == 8'h00, res[5], st.a[3:0] != 4'h0, res[3],
                 st.a == 8'h80, 1'b1, st.a != 8'h00};
        return exp;
    endfunction

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic testReset();
        edState_t exp;
        exp = '{a: 8'hFF, f: 8'hFF, bc: 16'hFFFF, de: 16'hFFFF, hl: 16'hFFFF,
                sp: 16'hFFFF, i: 8'h00, r: 8'h00, im: 2'd0, iff2: 1'b0};
        checkState("reset", coreState, exp);
        checkCount("opReady after reset", int'(opReady), 1);
    endtask

    task automatic testNeg();
        edState_t st;
        for (int n = 0; n < 8; n++) begin
            makeRandomState(st);
            if (n == 0) st.a = 8'h00;
            if (n == 1) st.a = 8'h01;
            if (n == 2) st.a = 8'h80;
            loadRegs(st);
            runOp("NEG", 8'h44, negModel(st), 1);
        end
    endtask

    task automatic testIm();
        logic [7:0] codes [3];
        edState_t   st;
        edState_t   exp;
        codes = '{8'h46, 8'h56, 8'h5E};
        for (int n = 0; n < 3; n++) begin
            makeRandomState(st);
            loadRegs(st);
            exp    = st;
            exp.im = 2'(n);
            runOp("IM", codes[n], exp, 1);
        end
    endtask

    task automatic testIr();
        edState_t st;
        edState_t exp;
        for (int n = 0; n < 3; n++) begin
            makeRandomState(st);
            // the first pass makes LD A,I and LD A,R load zero.
            if (n == 0) begin
                st.i = 8'h00;
                st.r = 8'h00;
            end
            // iff2 and the carry alternate so that PV and C are seen both ways.
            st.iff2 = n[0];
            st.f[0] = ~n[0];
            loadRegs(st);
            exp   = st;
            exp.i = st.a;
            runOp("LD I,A", 8'h47, exp, 1);
            loadRegs(st);
            exp   = st;
            exp.r = st.a;
            runOp("LD R,A", 8'h4F, exp, 1);
            loadRegs(st);
            exp   = st;
            exp.a = st.i;
            exp.f = {st.i[7], st.i == 8'h00, st.i[5], 1'b0, st.i[3], st.iff2, 1'b0, st.f[0]};
            runOp("LD A,I", 8'h57, exp, 1);
            loadRegs(st);
            exp   = st;
            exp.a = st.r;
            exp.f = {st.r[7], st.r == 8'h00, st.r[5], 1'b0, st.r[3], st.iff2, 1'b0, st.f[0]};
            runOp("LD A,R", 8'h5F, exp, 1);
        end
    endtask

    task automatic testWord();
        edState_t    st;
        edState_t    exp;
        logic [15:0] rr;
        logic [15:0] res;
        logic [16:0] wide;
        logic        ovf;
        for (int p = 0; p < 4; p++) begin
            for (int sub = 0; sub < 2; sub++) begin
                for (int n = 0; n < 3; n++) begin
                    makeRandomState(st);
                    // a zero high byte with a live low byte exercises the word Z flag.
                    if (n == 0) begin
                        st.hl[15:8] = 8'h00;
                        st.bc       = 16'h0000;
                        st.de       = 16'h0000;
                        st.sp       = 16'h0000;
                        st.f[0]     = 1'b0;
                    end
                    // the second pass picks the pair so that the whole word result is zero.
                    if (n == 1) begin
                        st.f[0] = 1'b0;
                        rr      = (sub == 1) ? st.hl : 16'h0000 - st.hl;
                        case (p)
                            0:       st.bc = rr;
                            1:       st.de = rr;
                            2:       st.hl = 16'h8000;
                            default: st.sp = rr;
                        endcase
                    end
                    loadRegs(st);
                    case (p)
                        0:       rr = st.bc;
                        1:       rr = st.de;
                        2:       rr = st.hl;
                        default: rr = st.sp;
                    endcase
                    if (sub == 1) begin
                        wide = {1'b0, st.hl} - {1'b0, rr} - {16'd0, st.f[0]};
                        ovf  = (st.hl[15] != rr[15]) && (wide[15] != st.hl[15]);
                    end else begin
                        wide = {1'b0, st.hl} + {1'b0, rr} + {16'd0, st.f[0]};
                        ovf  = (st.hl[15] == rr[15]) && (wide[15] != st.hl[15]);
                    end
                    res    = wide[15:0];
                    exp    = st;
                    exp.hl = res;
                    exp.f  = {res[15], res == 16'h0000, res[13], st.hl[12] ^ rr[12] ^ res[12],
                              res[11], ovf, sub == 1, wide[16]};
                    runOp(sub == 1 ? "SBC HL" : "ADC HL",
                          {4'h4 | 4'(p), sub == 1 ? 4'h2 : 4'hA}, exp, 2);
                end
            end
        end
    endtask

    task automatic testUndefined();
        logic [7:0] codes [3];
        edState_t   st;
        int         cycles;
        codes = '{8'h00, 8'h77, 8'hFF};
        for (int n = 0; n < 3; n++) begin
            makeRandomState(st);
            loadRegs(st);
            runOp("undefined opcode", codes[n], st, 1);
        end
        // NEG twice would restore A, so one accept shows up as a negated A.
        makeRandomState(st);
        st.a = st.a | 8'h01;
        loadRegs(st);
        sendOpcode(8'h44, 1'b1);
        waitReady(cycles);
        opValid = 1'b0;
        checkCount("held NEG busy cycles", cycles, 1);
        nextCycle();
        checkCount("opReady after held NEG", int'(opReady), 1);
        checkState("held NEG", coreState, negModel(st));
    endtask

    initial begin
        seed         = 82;
        errorCount   = 0;
        timeoutCount = 0;
        clk          = 1'b0;
        arstN        = 1'b0;
        opValid      = 1'b0;
        opCode       = '0;
        loadEn       = 1'b0;
        loadState    = '0;
        repeat (10) @(posedge clk);
        #1;
        arstN = 1'b1;
        nextCycle();
        testReset();
        testNeg();
        testIm();
        testIr();
        testWord();
        testUndefined();
        $display("Summary: %0d value errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: z80Ed.f
+incdir+verilog
verilog/edPkg.sv
verilog/edOpDecoder.sv
verilog/edSequencer.sv
verilog/phaseTimer.sv
verilog/edAlu.sv
verilog/edRegFile.sv
verilog/edCoreTop.sv
sim/edCoreTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the ED-page core testbench with Verilator, runs it and checks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module edCoreTb -f z80Ed.f -o edCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/edCoreSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
